// File: src/tcp_tx_params.svh
`ifndef TCP_TX_PARAMS_SVH
`define TCP_TX_PARAMS_SVH

// log2 of the payload ring buffer size in bytes
`define TCP_TX_RAM_DEPTH 10

// log2 of the number of segments that can be in flight
`define TCP_TX_PKT_DEPTH 3

// idle cycles before a non-empty open segment is closed
`define TCP_TX_WAIT_TICKS 20

`endif

// File: src/tcp_tx_pkg.sv
package tcp_tx_pkg;

  typedef logic [31:0] tcp_num_t;   // sequence or ack number
  typedef logic [15:0] tcp_len_t;   // segment length in bytes
  typedef logic [1:0]  cfg_addr_t;

  // one entry of the in-flight table
  typedef struct packed {
    logic        present;  // entry valid
    logic        sent;     // transmitted at least once
    tcp_num_t    start;    // seq of first byte
    tcp_len_t    length;
    logic [7:0]  tries;    // transmissions so far
    logic [31:0] timer;    // ticks left before retransmit
  } tcp_pkt_t;

  // configuration register map
  localparam cfg_addr_t reg_mss   = 2'd0;
  localparam cfg_addr_t reg_rto   = 2'd1;
  localparam cfg_addr_t reg_tries = 2'd2;

  localparam tcp_len_t    mss_reset   = 16'd64;
  localparam logic [31:0] rto_reset   = 32'd2000;
  localparam logic [7:0]  tries_reset = 8'd5;

endpackage

// File: src/tcp_tx_regs.sv
`timescale 1ns/1ns

module tcp_tx_regs (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  cfg_we,
  input  tcp_tx_pkg::cfg_addr_t cfg_addr,
  input  logic [31:0]           cfg_wdata,
  output tcp_tx_pkg::tcp_len_t  mss,
  output logic [31:0]           rto,
  output logic [7:0]            max_tries
);
  import tcp_tx_pkg::*;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mss       <= mss_reset;
      rto       <= rto_reset;
      max_tries <= tries_reset;
    end else if (cfg_we) begin
      case (cfg_addr)
        reg_mss: begin
          if (cfg_wdata[15:0] != '0) begin // zero payload makes no sense
            mss <= cfg_wdata[15:0];
          end
        end
        reg_rto: begin
          rto <= cfg_wdata;
        end
        reg_tries: begin
          max_tries <= cfg_wdata[7:0];
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: src/tcp_tx_buf.sv
`timescale 1ns/1ns
`include "tcp_tx_params.svh"

module tcp_tx_buf (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         init,
  input  tcp_tx_pkg::tcp_num_t         isn,
  input  logic [7:0]                   dat,
  input  logic                         val,
  input  tcp_tx_pkg::tcp_num_t         seq,
  input  tcp_tx_pkg::tcp_num_t         ack,
  input  logic [`TCP_TX_RAM_DEPTH-1:0] addr,
  output logic [7:0]                   rd_dat,
  output logic                         full,
  output logic                         empty
);
  import tcp_tx_pkg::*;

  localparam int size = 2 ** `TCP_TX_RAM_DEPTH;

  logic [7:0] mem [size];
  tcp_num_t   ack_q;   // oldest unacked byte
  tcp_num_t   fill;
  tcp_num_t   ack_adv;

  assign fill    = seq - ack_q;
  assign ack_adv = ack - ack_q;
  assign full    = fill >= tcp_num_t'(size);
  assign empty   = fill == '0;

  always_ff @(posedge clk) begin
    if (val) begin
      mem[seq[`TCP_TX_RAM_DEPTH-1:0]] <= dat;
    end
    rd_dat <= mem[addr]; // one cycle read latency
  end

  // only accept an ack that lands inside the stored window
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q <= '0;
    end else if (init) begin
      ack_q <= isn;
    end else if (ack_adv != '0 && ack_adv <= fill) begin
      ack_q <= ack;
    end
  end

endmodule

// File: src/tcp_tx_add.sv
`timescale 1ns/1ns
`include "tcp_tx_params.svh"

module tcp_tx_add (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 init,
  input  tcp_tx_pkg::tcp_num_t isn,
  input  logic                 val,
  input  logic                 snd,
  input  tcp_tx_pkg::tcp_len_t mss,
  output tcp_tx_pkg::tcp_num_t loc_seq,
  output tcp_tx_pkg::tcp_pkt_t new_pkt,
  output logic                 add,
  output logic                 pend
);
  import tcp_tx_pkg::*;

  tcp_num_t    seg_start;
  tcp_len_t    seg_len;
  tcp_len_t    len_nxt;  // length including this cycle's byte
  logic [15:0] idle_cnt;
  logic        close_mss;
  logic        close_snd;
  logic        close_idle;

  assign len_nxt    = seg_len + tcp_len_t'(val);
  assign close_mss  = len_nxt != '0 && len_nxt >= mss;
  assign close_snd  = snd && len_nxt != '0;
  assign close_idle = seg_len != '0 && idle_cnt == 16'(`TCP_TX_WAIT_TICKS);
  assign add        = close_mss || close_snd || close_idle;
  assign pend       = seg_len != '0;

  always_comb begin
    new_pkt         = '0;
    new_pkt.present = 1'b1;
    new_pkt.start   = seg_start;
    new_pkt.length  = len_nxt; // closing byte goes with it
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      loc_seq   <= '0;
      seg_start <= '0;
      seg_len   <= '0;
      idle_cnt  <= '0;
    end else if (init) begin
      loc_seq   <= isn;
      seg_start <= isn;
      seg_len   <= '0;
      idle_cnt  <= '0;
    end else begin
      if (val) begin
        loc_seq <= loc_seq + 1'b1;
      end
      if (add) begin
        seg_start <= seg_start + tcp_num_t'(len_nxt);
        seg_len   <= '0;
      end else begin
        seg_len <= len_nxt;
      end
      if (add || val || seg_len == '0) begin
        idle_cnt <= '0;
      end else begin
        idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

endmodule

// File: src/tcp_tx_info.sv
`timescale 1ns/1ns
`include "tcp_tx_params.svh"

module tcp_tx_info (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         init,
  input  tcp_tx_pkg::tcp_pkt_t         new_pkt,
  input  logic                         add,
  input  logic [`TCP_TX_PKT_DEPTH-1:0] ptr,
  input  tcp_tx_pkg::tcp_pkt_t         pkt_w,
  input  logic                         upd,
  output tcp_tx_pkg::tcp_pkt_t         pkt_r,
  output logic [`TCP_TX_PKT_DEPTH:0]   free_cnt,
  output logic                         full
);
  import tcp_tx_pkg::*;

  localparam int dw = `TCP_TX_PKT_DEPTH;
  localparam int n  = 2 ** dw;

  tcp_pkt_t      tbl [n];
  logic [dw-1:0] free_idx;
  logic          free_hit;

  // walk down so the lowest free slot wins
  always_comb begin
    free_idx = '0;
    free_hit = 1'b0;
    free_cnt = '0;
    for (int i = n - 1; i >= 0; i--) begin
      if (!tbl[i].present) begin
        free_idx = dw'(i);
        free_hit = 1'b1;
        free_cnt = free_cnt + 1'b1;
      end
    end
  end

  assign full  = !free_hit;
  assign pkt_r = tbl[ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < n; i++) tbl[i] <= '0;
    end else if (init) begin
      for (int i = 0; i < n; i++) tbl[i] <= '0;
    end else begin
      if (upd) begin
        tbl[ptr] <= pkt_w;
      end
      if (add && free_hit) begin
        tbl[free_idx] <= new_pkt; // scanner never touches a free slot
      end
    end
  end

endmodule

// File: src/tcp_tx_scan.sv
`timescale 1ns/1ns
`include "tcp_tx_params.svh"

module tcp_tx_scan (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         init,
  input  tcp_tx_pkg::tcp_num_t         rem_ack,
  input  logic                         ack_val,
  input  logic [31:0]                  rto,
  input  logic [7:0]                   max_tries,
  input  logic                         done,
  output logic [`TCP_TX_PKT_DEPTH-1:0] ptr,
  output tcp_tx_pkg::tcp_pkt_t         pkt_w,
  output logic                         upd,
  input  tcp_tx_pkg::tcp_pkt_t         pkt_r,
  output logic                         pend,
  output tcp_tx_pkg::tcp_num_t         pend_seq,
  output tcp_tx_pkg::tcp_len_t         pend_len,
  output tcp_tx_pkg::tcp_num_t         last_ack,
  output logic                         force_dcn
);
  import tcp_tx_pkg::*;

  localparam int n = 2 ** `TCP_TX_PKT_DEPTH;

  logic     ack_seen;
  tcp_num_t ack_diff;
  tcp_num_t ack_step;
  logic     acked;
  logic     needs_tx;
  logic     give_up;
  logic     pick;

  assign ack_diff = last_ack - (pkt_r.start + tcp_num_t'(pkt_r.length));
  assign ack_step = rem_ack - last_ack;
  assign acked    = ack_seen && !ack_diff[31] && !pend; // pending entry stays until done
  assign needs_tx = pkt_r.present && !acked && !done &&
                    (!pkt_r.sent || pkt_r.timer == '0);
  assign give_up  = needs_tx && pkt_r.tries >= max_tries;
  assign pick     = needs_tx && !give_up && !pend;

  always_comb begin
    pkt_w = pkt_r;
    upd   = pkt_r.present;
    if (done) begin
      pkt_w.sent  = 1'b1;
      pkt_w.tries = pkt_r.tries + 1'b1;
      pkt_w.timer = rto;
    end else if (acked) begin
      pkt_w = '0;
    end else if (pkt_r.sent) begin
      // one visit per round, so a round's worth of ticks has passed
      pkt_w.timer = (pkt_r.timer > 32'(n)) ? pkt_r.timer - 32'(n) : '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr       <= '0;
      pend      <= 1'b0;
      last_ack  <= '0;
      ack_seen  <= 1'b0;
      force_dcn <= 1'b0;
    end else if (init) begin
      ptr       <= '0;
      pend      <= 1'b0;
      last_ack  <= '0;
      ack_seen  <= 1'b0;
      force_dcn <= 1'b0;
    end else begin
      if (!pend && !pick) begin
        ptr <= ptr + 1'b1; // held on the pending entry until done
      end
      if (done) begin
        pend <= 1'b0;
      end else if (pick) begin
        pend <= 1'b1;
      end
      if (give_up) begin
        force_dcn <= 1'b1; // out of retries
      end
      if (ack_val && (!ack_seen || (!ack_step[31] && ack_step != '0))) begin
        last_ack <= rem_ack;
        ack_seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pick) begin
      pend_seq <= pkt_r.start;
      pend_len <= pkt_r.length;
    end
  end

endmodule

// File: src/tcp_tx_strm.sv
`timescale 1ns/1ns
`include "tcp_tx_params.svh"

module tcp_tx_strm (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         init,
  input  logic                         pend,
  input  tcp_tx_pkg::tcp_num_t         pend_seq,
  input  tcp_tx_pkg::tcp_len_t         pend_len,
  input  logic                         send,
  input  logic [7:0]                   rd_dat,
  output logic                         req,
  output tcp_tx_pkg::tcp_num_t         req_seq,
  output tcp_tx_pkg::tcp_len_t         req_len,
  output logic [`TCP_TX_RAM_DEPTH-1:0] addr,
  output logic [7:0]                   strm_dat,
  output logic                         strm_val,
  output logic                         strm_sof,
  output logic                         strm_eof,
  output logic                         done
);
  import tcp_tx_pkg::*;

  logic     busy;   // from send until done
  logic     rd_en;  // addr holds a byte to read
  logic     first;
  logic     last_rd;
  logic     load;
  tcp_len_t cnt;    // bytes left to read

  assign load     = pend && !busy && !req;
  assign last_rd  = rd_en && cnt == 16'd1;
  assign strm_dat = rd_dat;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {req, busy, rd_en, first} <= '0;
      {strm_val, strm_sof, strm_eof, done} <= '0;
    end else if (init) begin
      {req, busy, rd_en, first} <= '0;
      {strm_val, strm_sof, strm_eof, done} <= '0;
    end else begin
      strm_val <= rd_en; // strobes trail addr by the read latency
      strm_sof <= rd_en && first;
      strm_eof <= last_rd;
      done     <= last_rd;
      if (rd_en) first <= 1'b0;
      if (last_rd) rd_en <= 1'b0;
      if (done) busy <= 1'b0;
      if (req && send) begin
        req   <= 1'b0;
        busy  <= 1'b1;
        rd_en <= 1'b1;
        first <= 1'b1;
      end else if (load) begin
        req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      req_seq <= pend_seq;
      req_len <= pend_len;
    end
    if (req && send) begin
      addr <= req_seq[`TCP_TX_RAM_DEPTH-1:0];
      cnt  <= req_len;
    end else if (rd_en) begin
      addr <= addr + 1'b1;
      cnt  <= cnt - 1'b1;
    end
  end

endmodule

// File: src/tcp_tx_ctl.sv
`timescale 1ns/1ns
`include "tcp_tx_params.svh"

module tcp_tx_ctl (
  input  logic                  clk,
  input  logic                  arst_n,
  // user byte stream
  input  logic [7:0]            dat,
  input  logic                  val,
  input  logic                  snd,
  output logic                  cts,
  // connection side
  input  logic                  connected,
  input  logic                  init,
  input  tcp_tx_pkg::tcp_num_t  isn,
  input  tcp_tx_pkg::tcp_num_t  rem_ack,
  input  logic                  ack_val,
  input  logic                  cfg_we,
  input  tcp_tx_pkg::cfg_addr_t cfg_addr,
  input  logic [31:0]           cfg_wdata,
  // packet engine
  output logic                  req,
  output tcp_tx_pkg::tcp_num_t  req_seq,
  output tcp_tx_pkg::tcp_len_t  req_len,
  input  logic                  send,
  output logic [7:0]            strm_dat,
  output logic                  strm_val,
  output logic                  strm_sof,
  output logic                  strm_eof,
  output logic                  force_dcn
);
  import tcp_tx_pkg::*;

  tcp_len_t    mss;
  logic [31:0] rto;
  logic [7:0]  max_tries;
  logic        wr;        // accepted user byte
  tcp_num_t    loc_seq;
  tcp_num_t    last_ack;
  tcp_pkt_t    new_pkt;
  tcp_pkt_t    pkt_w;
  tcp_pkt_t    pkt_r;
  logic        add;
  logic        upd;
  logic        info_full;
  logic        buf_full;
  logic        pend;
  logic        done;
  tcp_num_t    pend_seq;
  tcp_len_t    pend_len;
  logic [7:0]  rd_dat;
  logic [`TCP_TX_PKT_DEPTH-1:0] tbl_ptr;
  logic [`TCP_TX_RAM_DEPTH-1:0] buf_addr;

  assign cts = connected && !info_full && !buf_full;
  assign wr  = val && cts;

  tcp_tx_regs i_regs (
    .clk(clk), .arst_n(arst_n), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .mss(mss), .rto(rto), .max_tries(max_tries)
  );

  tcp_tx_buf i_buf (
    .clk(clk), .arst_n(arst_n), .init(init), .isn(isn), .dat(dat), .val(wr),
    .seq(loc_seq), .ack(last_ack), .addr(buf_addr), .rd_dat(rd_dat),
    .full(buf_full), .empty()
  );

  tcp_tx_add i_add (
    .clk(clk), .arst_n(arst_n), .init(init), .isn(isn), .val(wr), .snd(snd),
    .mss(mss), .loc_seq(loc_seq), .new_pkt(new_pkt), .add(add), .pend()
  );

  tcp_tx_info i_info (
    .clk(clk), .arst_n(arst_n), .init(init), .new_pkt(new_pkt), .add(add),
    .ptr(tbl_ptr), .pkt_w(pkt_w), .upd(upd), .pkt_r(pkt_r), .free_cnt(),
    .full(info_full)
  );

  tcp_tx_scan i_scan (
    .clk(clk), .arst_n(arst_n), .init(init), .rem_ack(rem_ack), .ack_val(ack_val),
    .rto(rto), .max_tries(max_tries), .done(done), .ptr(tbl_ptr), .pkt_w(pkt_w),
    .upd(upd), .pkt_r(pkt_r), .pend(pend), .pend_seq(pend_seq), .pend_len(pend_len),
    .last_ack(last_ack), .force_dcn(force_dcn)
  );

  tcp_tx_strm i_strm (
    .clk(clk), .arst_n(arst_n), .init(init), .pend(pend), .pend_seq(pend_seq),
    .pend_len(pend_len), .send(send), .rd_dat(rd_dat), .req(req), .req_seq(req_seq),
    .req_len(req_len), .addr(buf_addr), .strm_dat(strm_dat), .strm_val(strm_val),
    .strm_sof(strm_sof), .strm_eof(strm_eof), .done(done)
  );

endmodule

// File: testbench/tcp_tx_ctl_tb.sv
`timescale 1ns/1ns
`include "tcp_tx_params.svh"

module tcp_tx_ctl_tb;
  import tcp_tx_pkg::*;

  localparam int n_pkt       = 2 ** `TCP_TX_PKT_DEPTH;
  localparam int buf_bytes   = 2 ** `TCP_TX_RAM_DEPTH;
  localparam int default_rto = 2000;
  localparam int short_rto   = 300;
  localparam int retries     = 3;
  localparam int test_bytes  = 100 + 57 + n_pkt * 16 + 10;
  localparam int watchdog_cycles = (test_bytes * 200 + default_rto + short_rto) * retries;

  logic        clk;
  logic        arst_n;
  logic [7:0]  dat;
  logic        val, snd, cts, connected, init, ack_val, cfg_we, send;
  tcp_num_t    isn, rem_ack, req_seq;
  cfg_addr_t   cfg_addr;
  logic [31:0] cfg_wdata;
  logic        req, strm_val, strm_sof, strm_eof, force_dcn;
  tcp_len_t    req_len;
  logic [7:0]  strm_dat;

  logic [7:0] ref_mem [logic [31:0]]; // every accepted byte by seq
  tcp_num_t   exp_seq [$];
  tcp_num_t   cap_seq [$];
  tcp_len_t   exp_len [$];
  tcp_len_t   cap_len [$];
  tcp_num_t   wr_seq;
  tcp_num_t   exp_next;
  int         tb_mss;
  string      test_name;
  int         n_tests, n_failed, n_checks, n_errors, test_err0;

  tcp_tx_ctl i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [7:0] ref_byte(tcp_num_t seq);
    if (!ref_mem.exists(seq)) begin
      return 'x;
    end
    return ref_mem[seq];
  endfunction

  // length of segment idx when a back-to-back run is cut at mss
  function automatic int split_len(int total, int idx, int mss);
    int rest;
    rest = total - idx * mss;
    return (rest > mss) ? mss : rest;
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic plan_run(input int total);
    int i;
    for (i = 0; i < (total + tb_mss - 1) / tb_mss; i++) begin
      exp_seq.push_back(exp_next);
      exp_len.push_back(tcp_len_t'(split_len(total, i, tb_mss)));
      exp_next = exp_next + tcp_num_t'(split_len(total, i, tb_mss));
    end
  endtask

  task automatic compare_segments();
    int i;
    check("segment count", exp_seq.size(), cap_seq.size());
    for (i = 0; i < exp_seq.size() && i < cap_seq.size(); i++) begin
      check("segment seq", exp_seq[i], cap_seq[i]);
      check("segment len", 32'(exp_len[i]), 32'(cap_len[i]));
    end
    exp_seq.delete();
    exp_len.delete();
    cap_seq.delete();
    cap_len.delete();
  endtask

  task automatic wait_segments(input int n, input int limit);
    int t;
    t = 0;
    while (cap_seq.size() < n && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (cap_seq.size() < n) begin
      n_errors++;
      $display("%s: only %0d of %0d segments were streamed within %0d cycles",
               test_name, cap_seq.size(), n, limit);
    end
  endtask

  task automatic cfg_write(input cfg_addr_t addr, input logic [31:0] data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic open_conn(input tcp_num_t start);
    @(negedge clk);
    init = 1'b1;
    isn  = start;
    @(negedge clk);
    init     = 1'b0;
    wr_seq   = start;
    exp_next = start;
  endtask

  task automatic write_bytes(input int count);
    int taken;
    taken = 0;
    while (taken < count) begin
      @(negedge clk);
      check("cts while writing", 1, cts);
      val = cts;
      if (cts) begin
        dat = 8'($urandom);
        ref_mem[wr_seq] = dat;
        wr_seq++;
        taken++;
      end
    end
    @(negedge clk);
    val = 1'b0;
  endtask

  task automatic pulse_snd();
    snd = 1'b1;
    @(negedge clk);
    snd = 1'b0;
  endtask

  task automatic ack_all();
    @(negedge clk);
    rem_ack = wr_seq;
    ack_val = 1'b1;
    @(negedge clk);
    ack_val = 1'b0;
    repeat (3 * n_pkt) @(negedge clk); // a few scan rounds to free entries
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    if (n_errors == test_err0) begin
      $display("test %s: ok", test_name);
    end else begin
      n_failed++;
      $display("test %s: %0d errors", test_name, n_errors - test_err0);
    end
  endtask

  // engine model that takes each segment and checks its stream
  initial begin : engine
    int i;
    tcp_num_t s_seq;
    tcp_len_t s_len;
    forever begin
      @(negedge clk);
      if (req) begin
        s_seq = req_seq;
        s_len = req_len;
        repeat ($urandom_range(5, 0)) @(negedge clk);
        check("req held", 1, req);
        check("req_seq held", s_seq, req_seq);
        check("req_len held", 32'(s_len), 32'(req_len));
        send = 1'b1;
        @(negedge clk);
        send = 1'b0;
        check("val before first byte", 0, strm_val);
        @(negedge clk);
        for (i = 0; i < s_len; i++) begin
          check("stream val", 1, strm_val);
          check("stream byte", ref_byte(s_seq + tcp_num_t'(i)), strm_dat);
          check("stream sof", 32'(i == 0), strm_sof);
          check("stream eof", 32'(i == s_len - 1), strm_eof);
          check("req while streaming", 0, req);
          @(negedge clk);
        end
        check("val after last byte", 0, strm_val);
        cap_seq.push_back(s_seq);
        cap_len.push_back(s_len);
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main
    int n;
    int t;
    {arst_n, dat, val, snd, connected, init, ack_val, cfg_we, send} = '0;
    {isn, rem_ack, cfg_addr, cfg_wdata} = '0;
    {n_tests, n_failed, n_checks, n_errors} = '0;
    tb_mss = 64;
    void'($urandom(32'hf7c8_5c8b));
    repeat (10) @(negedge clk);
    arst_n = 1'b1;

    start_test("reset_idle");
    @(negedge clk);
    check("req", 0, req);
    check("strm_val", 0, strm_val);
    check("force_dcn", 0, force_dcn);
    check("cts before init", 0, cts);
    connected = 1'b1;
    open_conn($urandom);
    check("cts after init", 1, cts);
    end_test();

    start_test("payload_numbering");
    open_conn($urandom);
    write_bytes(100);
    plan_run(100);
    wait_segments(exp_seq.size(), 200 * 100);
    compare_segments();
    ack_all();
    end_test();

    start_test("segmentation");
    cfg_write(reg_mss, 16);
    tb_mss = 16;
    write_bytes(50);
    plan_run(50);
    repeat (`TCP_TX_WAIT_TICKS + 10) @(negedge clk); // idle flush of the tail
    write_bytes(7);
    pulse_snd();
    plan_run(7);
    wait_segments(exp_seq.size(), 200 * 57);
    compare_segments();
    ack_all();
    end_test();

    start_test("ack_backpressure");
    n = 0;
    @(negedge clk);
    while (cts && n < buf_bytes + 16) begin
      dat = 8'($urandom);
      val = 1'b1;
      ref_mem[wr_seq] = dat;
      wr_seq++;
      n++;
      @(negedge clk);
    end
    repeat (5) begin
      check("cts stays low", 0, cts); // val still high, bytes must be dropped
      @(negedge clk);
    end
    val = 1'b0;
    check("bytes in flight", 1, n <= buf_bytes);
    plan_run(n);
    wait_segments(exp_seq.size(), 200 * n);
    check("segments in flight", 1, cap_seq.size() <= n_pkt);
    compare_segments();
    ack_all();
    check("cts after ack", 1, cts);
    repeat (default_rto + 500) @(negedge clk);
    check("retransmits after ack", 0, cap_seq.size());
    end_test();

    start_test("retransmit_giveup");
    cfg_write(reg_rto, short_rto);
    cfg_write(reg_tries, retries);
    write_bytes(10);
    pulse_snd();
    plan_run(10);
    repeat (retries - 1) begin
      exp_seq.push_back(exp_seq[0]);
      exp_len.push_back(exp_len[0]);
    end
    wait_segments(retries, retries * (short_rto + 200));
    check("force_dcn before give-up", 0, force_dcn);
    t = 0;
    while (!force_dcn && t < short_rto + 200) begin
      @(negedge clk);
      t++;
    end
    check("force_dcn", 1, force_dcn);
    repeat (short_rto + 200) @(negedge clk);
    compare_segments();
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: tcp_tx.f
+incdir+src
src/tcp_tx_pkg.sv
src/tcp_tx_regs.sv
src/tcp_tx_buf.sv
src/tcp_tx_add.sv
src/tcp_tx_info.sv
src/tcp_tx_scan.sv
src/tcp_tx_strm.sv
src/tcp_tx_ctl.sv
testbench/tcp_tx_ctl_tb.sv

// File: Makefile
TOP = tcp_tx_ctl_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tcp_tx.f src/*.sv src/*.svh testbench/*.sv
	verilator --binary -Wno-fatal -j 0 --top-module $(TOP) -f tcp_tx.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only --timing -Wall --top-module tcp_tx_ctl -f tcp_tx.f

clean:
	rm -rf obj_dir
